// ==== list.f ====
+incdir+.
apu_cluster_pkg.sv
apu_arbiter.sv
int_mult_unit.sv
int_div_unit.sv
result_merge.sv
apu_cluster.sv
tb_clock_gen.sv
apu_cluster_tb.sv

// ==== apu_cluster_stim.txt ====
// Columns: core  unit_type  opcode  operand_a  operand_b  expected_result, all hex
// Unit type 0 mult, 1 div. Opcode 0 MUL 1 MULH 2 MULHU 3 DIV 4 DIVU 5 REM 6 REMU
0 1 3 FFFFFFF9 00000002 FFFFFFFD
0 0 0 00000007 FFFFFFFD FFFFFFEB
0 0 1 FFFFFFF9 00000003 FFFFFFFF
0 1 5 FFFFFFF9 00000002 FFFFFFFF
0 0 2 FFFFFFFF FFFFFFFF FFFFFFFE
1 1 4 00000064 00000007 0000000E
1 1 6 00000064 00000007 00000002
1 0 1 80000000 80000000 40000000
1 1 3 00000007 FFFFFFFE FFFFFFFD
1 0 0 12345678 00000010 23456780
2 1 3 0000002A 00000000 FFFFFFFF
2 1 5 0000002A 00000000 0000002A
2 1 4 0000002A 00000000 FFFFFFFF
2 1 6 FFFFFFF0 00000000 FFFFFFF0
2 0 2 80000000 00000002 00000001
3 1 3 80000000 FFFFFFFF 80000000
3 1 5 80000000 FFFFFFFF 00000000
3 0 0 FFFFFFFF FFFFFFFF 00000001
3 1 5 FFFFFFFB 00000000 FFFFFFFB
3 1 6 80000000 FFFFFFFF 80000000
// End marker
FF 0 0 00000000 00000000 00000000

// ==== apu_cluster_tb.sv ====
`include "apu_cluster_defs.svh"

module apu_cluster_tb;

   import apu_cluster_pkg::*;

   localparam int MAX_LINES  = 32;
   localparam int WORDS      = 6;
   localparam int DRIVE_DLY  = 2;
   localparam int MULT_LAT   = 1 + `MULT_STAGES + 1;

   logic                                  clk;
   logic                                  rst_n;
   logic [`NB_CORES-1:0]                  req;
   apu_req_t [`NB_CORES-1:0]              apu_req;
   logic [`NB_CORES-1:0]                  ack;
   logic [`NB_CORES-1:0]                  result_valid;
   logic [`NB_CORES-1:0][`DATA_WIDTH-1:0] result;

   logic [31:0] stim_mem [0:MAX_LINES*WORDS-1];
   int          line_q [`NB_CORES][$];
   int          line_cnt [`NB_CORES];
   int          idle_len [MAX_LINES];
   int          nb_lines;
   int          cycle_limit;
   int          cycle_cnt;
   integer      seed;

   int          ack_cnt [`NB_CORES];
   int          rsp_cnt [`NB_CORES];
   int          skip_cnt [`NB_CORES][`NB_CORES];
   logic        busy_div [`NB_CORES];
   logic        mult_overlap;

   tb_clock_gen #(
      .PERIOD       (40),
      .RESET_CYCLES (5)
   ) i_tb_clock_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   apu_cluster i_apu_cluster (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .req_i          (req),
      .apu_req_i      (apu_req),
      .ack_o          (ack),
      .result_valid_o (result_valid),
      .result_o       (result)
   );

   //////////////////////////////////////////////////////////////////////
   // Error handling
   //////////////////////////////////////////////////////////////////////

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
      if (actual !== expected) begin
         stop_on_error($sformatf("FAIL %0t: %s, got %h, expected %h",
                                 $time, what, actual, expected));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   // Entries end at the FF marker in the core column
   task automatic load_stimulus();
      logic [31:0] core;
      $readmemh("apu_cluster_stim.txt", stim_mem);
      nb_lines = 0;
      while (nb_lines < MAX_LINES && stim_mem[nb_lines*WORDS] !== 32'hFF) begin
         core = stim_mem[nb_lines*WORDS];
         if ($isunknown(core) || core >= `NB_CORES) begin
            stop_on_error($sformatf("Stimulus file missing or bad core index at entry %0d",
                                    nb_lines));
         end
         line_q[core].push_back(nb_lines);
         line_cnt[core]++;
         // Idle gap after this entry, drawn in file order
         idle_len[nb_lines] = $unsigned($random(seed)) % 4;
         nb_lines++;
      end
      if (nb_lines == 0 || nb_lines == MAX_LINES) begin
         stop_on_error("Stimulus file is empty or has no end marker");
      end
   endtask

   // One core, one request at a time
   task automatic run_core(input int c);
      int       idx;
      int       lat;
      apu_req_t r;
      while (line_q[c].size() > 0) begin
         idx         = line_q[c].pop_front();
         r.apu_type  = apu_type_e'(stim_mem[idx*WORDS+1][0]);
         r.op        = apu_op_e'(stim_mem[idx*WORDS+2][2:0]);
         r.operand_a = stim_mem[idx*WORDS+3];
         r.operand_b = stim_mem[idx*WORDS+4];

         @(posedge clk);
         #DRIVE_DLY;
         apu_req[c]  = r;
         req[c]      = 1'b1;

         // Ack seen here is taken at the next rising edge
         @(negedge clk);
         while (!ack[c]) begin
            @(negedge clk);
         end
         @(posedge clk);
         #DRIVE_DLY;
         req[c]      = 1'b0;
         busy_div[c] = (r.apu_type == APU_DIV);

         lat = 0;
         do begin
            @(negedge clk);
            lat++;
         end while (!result_valid[c]);

         compare_values(result[c], stim_mem[idx*WORDS+5],
                        $sformatf("core %0d entry %0d result", c, idx));
         if (r.apu_type == APU_MULT) begin
            compare_values(lat, MULT_LAT,
                           $sformatf("core %0d entry %0d multiply latency", c, idx));
            for (int d = 0; d < `NB_CORES; d++) begin
               if (d != c && busy_div[d]) begin
                  mult_overlap = 1'b1;
               end
            end
         end
         #DRIVE_DLY;
         busy_div[c] = 1'b0;

         repeat (idle_len[idx]) @(posedge clk);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Monitor and timeout
   //////////////////////////////////////////////////////////////////////

   // Counts acks and results, and bounds how often a waiting divide is passed over
   always @(negedge clk) begin
      if (rst_n === 1'b1) begin
         for (int c = 0; c < `NB_CORES; c++) begin
            if (ack[c]) begin
               ack_cnt[c]++;
            end
            if (result_valid[c]) begin
               rsp_cnt[c]++;
            end
            if (req[c] && apu_req[c].apu_type == APU_DIV && !ack[c]) begin
               for (int d = 0; d < `NB_CORES; d++) begin
                  if (d != c && ack[d] && apu_req[d].apu_type == APU_DIV) begin
                     skip_cnt[c][d]++;
                     compare_values(skip_cnt[c][d] <= 1, 1,
                                    $sformatf("core %0d acked twice while core %0d waits",
                                              d, c));
                  end
               end
            end
            if (ack[c]) begin
               for (int d = 0; d < `NB_CORES; d++) begin
                  skip_cnt[c][d] = 0;
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
         stop_on_error($sformatf("Timeout after %0d cycles, requests still outstanding",
                                 cycle_cnt));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      req          = '0;
      apu_req      = '0;
      seed         = 61;
      cycle_cnt    = 0;
      cycle_limit  = 0;
      mult_overlap = 1'b0;
      for (int c = 0; c < `NB_CORES; c++) begin
         ack_cnt[c]  = 0;
         rsp_cnt[c]  = 0;
         line_cnt[c] = 0;
         busy_div[c] = 1'b0;
         for (int d = 0; d < `NB_CORES; d++) begin
            skip_cnt[c][d] = 0;
         end
      end

      load_stimulus();
      cycle_limit = nb_lines * 50 * `NB_CORES;

      // Quiet outputs through reset and a little after
      while (rst_n !== 1'b1) begin
         @(negedge clk);
         compare_values(ack, '0, "ack during reset");
         compare_values(result_valid, '0, "result valid during reset");
      end
      repeat (2) begin
         @(negedge clk);
         compare_values(ack, '0, "ack after reset");
         compare_values(result_valid, '0, "result valid after reset");
      end

      // All cores start together, first entries are divides
      for (int c = 0; c < `NB_CORES; c++) begin
         fork
            automatic int core = c;
            run_core(core);
         join_none
      end
      wait fork;

      // Stray results would show up here
      repeat (4) @(negedge clk);
      for (int c = 0; c < `NB_CORES; c++) begin
         compare_values(ack_cnt[c], line_cnt[c], $sformatf("core %0d ack count", c));
         compare_values(rsp_cnt[c], line_cnt[c], $sformatf("core %0d result count", c));
      end
      compare_values(mult_overlap, 1'b1, "multiply overlapping a divide");

      $display("Test OK");
      $finish;
   end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   // Release a little after the edge, like the other stimulus
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2 rst_n_o = 1'b1;
   end

endmodule

// ==== apu_cluster.sv ====
`include "apu_cluster_defs.svh"

module apu_cluster (
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,

   input  logic [`NB_CORES-1:0]                       req_i,
   input  apu_cluster_pkg::apu_req_t [`NB_CORES-1:0] apu_req_i,
   output logic [`NB_CORES-1:0]                       ack_o,

   output logic [`NB_CORES-1:0]                       result_valid_o,
   output logic [`NB_CORES-1:0][`DATA_WIDTH-1:0]      result_o
);

   import apu_cluster_pkg::*;

   logic [`NB_CORES-1:0] mult_ack;
   logic [`NB_CORES-1:0] div_ack;

   logic                 mult_valid;
   unit_req_t            mult_req;
   logic                 div_valid;
   logic                 div_ready;
   unit_req_t            div_req;

   logic                 mult_rsp_valid;
   unit_rsp_t            mult_rsp;
   logic                 div_rsp_valid;
   unit_rsp_t            div_rsp;

   //////////////////////////////////////////////////////////////////////
   // Arbiters, one per unit type
   //////////////////////////////////////////////////////////////////////

   apu_arbiter #(
      .UNIT_TYPE (APU_MULT)
   ) i_mult_arbiter (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (req_i),
      .apu_req_i    (apu_req_i),
      .ack_o        (mult_ack),
      .unit_valid_o (mult_valid),
      .unit_req_o   (mult_req),
      .unit_ready_i (1'b1)
   );

   apu_arbiter #(
      .UNIT_TYPE (APU_DIV)
   ) i_div_arbiter (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (req_i),
      .apu_req_i    (apu_req_i),
      .ack_o        (div_ack),
      .unit_valid_o (div_valid),
      .unit_req_o   (div_req),
      .unit_ready_i (div_ready)
   );

   // A core targets one unit at a time
   assign ack_o = mult_ack | div_ack;

   //////////////////////////////////////////////////////////////////////
   // Units and result return
   //////////////////////////////////////////////////////////////////////

   int_mult_unit i_int_mult_unit (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (mult_valid),
      .req_i       (mult_req),
      .rsp_valid_o (mult_rsp_valid),
      .rsp_o       (mult_rsp)
   );

   int_div_unit i_int_div_unit (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (div_valid),
      .req_ready_o (div_ready),
      .req_i       (div_req),
      .rsp_valid_o (div_rsp_valid),
      .rsp_o       (div_rsp)
   );

   result_merge i_result_merge (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .mult_valid_i   (mult_rsp_valid),
      .mult_rsp_i     (mult_rsp),
      .div_valid_i    (div_rsp_valid),
      .div_rsp_i      (div_rsp),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

endmodule

// ==== result_merge.sv ====
`include "apu_cluster_defs.svh"

module result_merge (
   input  logic                                        clk_i,
   input  logic                                        rst_n_i,

   input  logic                                        mult_valid_i,
   input  apu_cluster_pkg::unit_rsp_t                  mult_rsp_i,
   input  logic                                        div_valid_i,
   input  apu_cluster_pkg::unit_rsp_t                  div_rsp_i,

   output logic [`NB_CORES-1:0]                        result_valid_o,
   output logic [`NB_CORES-1:0][`DATA_WIDTH-1:0]       result_o
);

   import apu_cluster_pkg::*;

   logic [`NB_CORES-1:0] mult_hit;
   logic [`NB_CORES-1:0] div_hit;

   //////////////////////////////////////////////////////////////////////
   // Tag decode
   //////////////////////////////////////////////////////////////////////

   // Each unit hits at most one core, the two may hit different ones
   always_comb begin
      for (int c = 0; c < `NB_CORES; c++) begin
         mult_hit[c] = mult_valid_i && (mult_rsp_i.tag == c);
         div_hit[c]  = div_valid_i && (div_rsp_i.tag == c);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Per-core result registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         result_valid_o <= '0;
      end else begin
         result_valid_o <= mult_hit | div_hit;
      end
   end

   // A core has one request open, so both hits never target it at once
   always_ff @(posedge clk_i) begin
      for (int c = 0; c < `NB_CORES; c++) begin
         if (mult_hit[c]) begin
            result_o[c] <= mult_rsp_i.result;
         end else if (div_hit[c]) begin
            result_o[c] <= div_rsp_i.result;
         end
      end
   end

endmodule

// ==== int_div_unit.sv ====
`include "apu_cluster_defs.svh"

module int_div_unit (
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   input  logic                       req_valid_i,
   output logic                       req_ready_o,
   input  apu_cluster_pkg::unit_req_t req_i,

   output logic                       rsp_valid_o,
   output apu_cluster_pkg::unit_rsp_t rsp_o
);

   import apu_cluster_pkg::*;

   localparam int CNT_W = $clog2(`DIV_STEPS);

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DONE
   } div_state_e;

   div_state_e             state_q;
   logic [CNT_W-1:0]       count_q;
   logic                   rsp_valid_q;
   unit_rsp_t              rsp_q;

   logic [`DATA_WIDTH-1:0] quo_q;
   logic [`DATA_WIDTH-1:0] rem_q;
   logic [`DATA_WIDTH-1:0] dvs_q;
   logic                   quo_neg_q;
   logic                   rem_neg_q;
   apu_op_e                op_q;
   logic [`TAG_WIDTH-1:0]  tag_q;

   logic                   is_signed;
   logic                   a_neg;
   logic                   b_neg;
   logic [`DATA_WIDTH-1:0] a_abs;
   logic [`DATA_WIDTH-1:0] b_abs;
   logic [`DATA_WIDTH:0]   shifted;
   logic [`DATA_WIDTH:0]   diff;
   logic                   sub_ok;
   logic [`DATA_WIDTH-1:0] quo_fix;
   logic [`DATA_WIDTH-1:0] rem_fix;

   //////////////////////////////////////////////////////////////////////
   // Operand preparation
   //////////////////////////////////////////////////////////////////////

   assign is_signed = (req_i.op == OP_DIV) || (req_i.op == OP_REM);
   assign a_neg     = is_signed && req_i.operand_a[`DATA_WIDTH-1];
   assign b_neg     = is_signed && req_i.operand_b[`DATA_WIDTH-1];
   assign a_abs     = a_neg ? -req_i.operand_a : req_i.operand_a;
   assign b_abs     = b_neg ? -req_i.operand_b : req_i.operand_b;

   // Restoring step on the partial remainder
   assign shifted = {rem_q, quo_q[`DATA_WIDTH-1]};
   assign diff    = shifted - {1'b0, dvs_q};
   assign sub_ok  = (shifted >= {1'b0, dvs_q});

   // Sign fix for the signed ops
   assign quo_fix = quo_neg_q ? -quo_q : quo_q;
   assign rem_fix = rem_neg_q ? -rem_q : rem_q;

   assign req_ready_o = (state_q == IDLE);

   //////////////////////////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= IDLE;
         count_q     <= '0;
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= 1'b0;
         case (state_q)
            IDLE: begin
               count_q <= '0;
               if (req_valid_i) begin
                  state_q <= RUN;
               end
            end
            RUN: begin
               count_q <= count_q + 1'b1;
               if (count_q == `DIV_STEPS - 1) begin
                  state_q <= DONE;
               end
            end
            DONE: begin
               state_q     <= IDLE;
               rsp_valid_q <= 1'b1;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Datapath
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      case (state_q)
         IDLE: begin
            if (req_valid_i) begin
               quo_q     <= a_abs;
               dvs_q     <= b_abs;
               rem_q     <= '0;
               // Zero divisor keeps the all ones quotient unsigned
               quo_neg_q <= (a_neg ^ b_neg) && (req_i.operand_b != '0);
               rem_neg_q <= a_neg;
               op_q      <= req_i.op;
               tag_q     <= req_i.tag;
            end
         end
         RUN: begin
            rem_q <= sub_ok ? diff[`DATA_WIDTH-1:0] : shifted[`DATA_WIDTH-1:0];
            quo_q <= {quo_q[`DATA_WIDTH-2:0], sub_ok};
         end
         DONE: begin
            rsp_q.tag    <= tag_q;
            rsp_q.result <= ((op_q == OP_DIV) || (op_q == OP_DIVU)) ? quo_fix : rem_fix;
         end
         default: ;
      endcase
   end

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_o       = rsp_q;

endmodule

// ==== int_mult_unit.sv ====
`include "apu_cluster_defs.svh"

module int_mult_unit (
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   input  logic                       req_valid_i,
   input  apu_cluster_pkg::unit_req_t req_i,

   output logic                       rsp_valid_o,
   output apu_cluster_pkg::unit_rsp_t rsp_o
);

   import apu_cluster_pkg::*;

   localparam int LAST = `MULT_STAGES - 1;

   logic                            mul_signed;
   logic signed [`DATA_WIDTH:0]     a_ext;
   logic signed [`DATA_WIDTH:0]     b_ext;
   logic signed [2*`DATA_WIDTH+1:0] prod_full;

   logic [`MULT_STAGES-1:0]         valid_q;
   logic [2*`DATA_WIDTH-1:0]        prod_q [`MULT_STAGES];
   apu_op_e                         op_q   [`MULT_STAGES];
   logic [`TAG_WIDTH-1:0]           tag_q  [`MULT_STAGES];

   //////////////////////////////////////////////////////////////////////
   // Product
   //////////////////////////////////////////////////////////////////////

   // MULHU is the only unsigned op, MUL low half is sign independent
   assign mul_signed = (req_i.op != OP_MULHU);

   // One extra bit makes a single signed multiply cover both cases
   assign a_ext = {mul_signed & req_i.operand_a[`DATA_WIDTH-1], req_i.operand_a};
   assign b_ext = {mul_signed & req_i.operand_b[`DATA_WIDTH-1], req_i.operand_b};

   assign prod_full = a_ext * b_ext;

   //////////////////////////////////////////////////////////////////////
   // Pipeline
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else begin
         valid_q[0] <= req_valid_i;
         for (int s = 1; s < `MULT_STAGES; s++) begin
            valid_q[s] <= valid_q[s-1];
         end
      end
   end

   // Payload follows the valid bit through every stage
   always_ff @(posedge clk_i) begin
      prod_q[0] <= prod_full[2*`DATA_WIDTH-1:0];
      op_q[0]   <= req_i.op;
      tag_q[0]  <= req_i.tag;
      for (int s = 1; s < `MULT_STAGES; s++) begin
         prod_q[s] <= prod_q[s-1];
         op_q[s]   <= op_q[s-1];
         tag_q[s]  <= tag_q[s-1];
      end
   end

   // Low half for MUL, high half otherwise
   always_comb begin
      rsp_o.tag = tag_q[LAST];
      if (op_q[LAST] == OP_MUL) begin
         rsp_o.result = prod_q[LAST][`DATA_WIDTH-1:0];
      end else begin
         rsp_o.result = prod_q[LAST][2*`DATA_WIDTH-1:`DATA_WIDTH];
      end
   end

   assign rsp_valid_o = valid_q[LAST];

endmodule

// ==== apu_arbiter.sv ====
`include "apu_cluster_defs.svh"

module apu_arbiter #(
   parameter apu_cluster_pkg::apu_type_e UNIT_TYPE = apu_cluster_pkg::APU_MULT
) (
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,

   input  logic [`NB_CORES-1:0]                       req_i,
   input  apu_cluster_pkg::apu_req_t [`NB_CORES-1:0] apu_req_i,
   output logic [`NB_CORES-1:0]                       ack_o,

   output logic                                       unit_valid_o,
   output apu_cluster_pkg::unit_req_t                 unit_req_o,
   input  logic                                       unit_ready_i
);

   import apu_cluster_pkg::*;

   logic [`NB_CORES-1:0]  match;
   logic [`TAG_WIDTH-1:0] ptr_q;
   logic [`TAG_WIDTH-1:0] cand_idx;
   logic [`TAG_WIDTH-1:0] grant_idx;
   logic [`TAG_WIDTH-1:0] ptr_next;
   logic                  grant_found;
   logic                  out_free;
   logic                  grant;
   logic                  valid_q;
   unit_req_t             req_q;

   //////////////////////////////////////////////////////////////////////
   // Request filter and round-robin pick
   //////////////////////////////////////////////////////////////////////

   // Only requests aimed at this unit take part
   always_comb begin
      for (int c = 0; c < `NB_CORES; c++) begin
         match[c] = req_i[c] && (apu_req_i[c].apu_type == UNIT_TYPE);
      end
   end

   // First match at or after the pointer wins
   always_comb begin
      grant_found = 1'b0;
      grant_idx   = '0;
      cand_idx    = '0;
      for (int k = 0; k < `NB_CORES; k++) begin
         cand_idx = (`TAG_WIDTH)'((int'(ptr_q) + k) % `NB_CORES);
         if (!grant_found && match[cand_idx]) begin
            grant_found = 1'b1;
            grant_idx   = cand_idx;
         end
      end
   end

   assign ptr_next = (grant_idx == `NB_CORES - 1) ? '0 : grant_idx + 1'b1;

   // Output slot is free, or the unit takes it this cycle
   assign out_free = !valid_q || unit_ready_i;
   assign grant    = grant_found && out_free;

   always_comb begin
      ack_o = '0;
      if (grant) begin
         ack_o[grant_idx] = 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output register toward the unit
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         ptr_q   <= '0;
      end else begin
         if (grant) begin
            valid_q <= 1'b1;
            ptr_q   <= ptr_next;
         end else if (unit_ready_i) begin
            valid_q <= 1'b0;
         end
      end
   end

   // Tag is the index of the granted core
   always_ff @(posedge clk_i) begin
      if (grant) begin
         req_q.op        <= apu_req_i[grant_idx].op;
         req_q.operand_a <= apu_req_i[grant_idx].operand_a;
         req_q.operand_b <= apu_req_i[grant_idx].operand_b;
         req_q.tag       <= grant_idx;
      end
   end

   assign unit_valid_o = valid_q;
   assign unit_req_o   = req_q;

endmodule

// ==== apu_cluster_pkg.sv ====
`include "apu_cluster_defs.svh"

package apu_cluster_pkg;

   //////////////////////////////////////////////////////////////////////
   // Encodings
   //////////////////////////////////////////////////////////////////////

   // Target unit of a request
   typedef enum logic {
      APU_MULT = 1'b0,
      APU_DIV  = 1'b1
   } apu_type_e;

   // Multiply ops first, then divide ops
   typedef enum logic [2:0] {
      OP_MUL   = 3'd0,
      OP_MULH  = 3'd1,
      OP_MULHU = 3'd2,
      OP_DIV   = 3'd3,
      OP_DIVU  = 3'd4,
      OP_REM   = 3'd5,
      OP_REMU  = 3'd6
   } apu_op_e;

   //////////////////////////////////////////////////////////////////////
   // Request and response bundles
   //////////////////////////////////////////////////////////////////////

   // Core side request
   typedef struct packed {
      apu_type_e              apu_type;
      apu_op_e                op;
      logic [`DATA_WIDTH-1:0] operand_a;
      logic [`DATA_WIDTH-1:0] operand_b;
   } apu_req_t;

   // Request after arbitration, tagged with the owning core
   typedef struct packed {
      apu_op_e                op;
      logic [`DATA_WIDTH-1:0] operand_a;
      logic [`DATA_WIDTH-1:0] operand_b;
      logic [`TAG_WIDTH-1:0]  tag;
   } unit_req_t;

   // Unit result, tag routes it back
   typedef struct packed {
      logic [`DATA_WIDTH-1:0] result;
      logic [`TAG_WIDTH-1:0]  tag;
   } unit_rsp_t;

endpackage

// ==== apu_cluster_defs.svh ====
`ifndef APU_CLUSTER_DEFS_SVH
`define APU_CLUSTER_DEFS_SVH

// Cores sharing the units
`define NB_CORES 4

// Operand and result width
`define DATA_WIDTH 32

// Core index tag, log2 of the core count
`define TAG_WIDTH 2

// Register stages in the multiplier
`define MULT_STAGES 2

// One divider iteration per result bit
`define DIV_STEPS `DATA_WIDTH

`endif
